//--- hw/fetch_pkg.sv
/*
 * Shared widths and types of the fetch front end.
 * HART_NUM must equal 2**HART_W because hart numbers wrap modulo HART_NUM.
 */
package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int WORD_W   = 32;             // Instruction and address width
    localparam int HART_NUM = 4;              // Hardware threads
    localparam int HART_W   = 2;              // Bits of a hart number

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic {
        HART_IDLE   = 1'b0,                   // Not started since reset
        HART_ACTIVE = 1'b1                    // Fetching, until reset
    } hart_state_t;

    typedef struct packed {
        logic [WORD_W-1:0] pc;                // Fetch address
        logic [WORD_W-1:0] insn;              // Word returned by memory
        logic [HART_W-1:0] hart;              // Owning hart
    } fetch_entry_t;

    // Encodings
    localparam logic [6:0]        OPC_JAL = 7'b110_1111;       // JAL major opcode
    localparam logic [WORD_W-1:0] OP_NOP  = 32'h0000_0013;     // addi x0, x0, 0

endpackage

//--- hw/fetch_bus.sv
/*
 * Single-entry valid/accept channel.
 * Valid is a level; the source keeps entry steady until accept is seen high.
 */
`timescale 1ns/1ps

interface fetch_bus #(
    parameter type entry_t = logic
);

    logic   valid;                            // Entry present
    entry_t entry;                            // Payload
    logic   accept;                           // Sink takes entry this cycle

    // Producer side
    modport source (output valid, output entry, input accept);

    // Consumer side
    modport sink (input valid, input entry, output accept);

endinterface

//--- hw/hart_ctrl.sv
/*
 * Hart run state and round-robin fetch selection.
 * A started hart runs until reset; starting an active hart has no effect.
 * Selection only moves on while the fetch stage is not holding.
 */
`timescale 1ns/1ps

module hart_ctrl
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              hstart,                 // Start request pulse
    input  logic [HART_W-1:0] hs_id,                  // Hart to start
    input  logic              advance,                // Fetch stage free
    output logic              sel_valid,              // Some hart active
    output logic [HART_W-1:0] sel_hart,               // Hart fetched this cycle
    output hart_state_t       hart_state [HART_NUM]   // Per-hart run state
);

    logic [HART_W-1:0] last_hart;                     // Last hart given a fetch

    // Scan from last_hart+1 around to last_hart, nearest active wins
    always_comb begin
        logic [HART_W-1:0] idx;
        sel_valid = 1'b0;
        sel_hart  = last_hart;
        for (int i = HART_NUM; i > 0; i--) begin
            idx = last_hart + HART_W'(i);             // Wraps modulo HART_NUM
            if (hart_state[idx] == HART_ACTIVE) begin
                sel_valid = 1'b1;
                sel_hart  = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_hart <= '0;
            for (int h = 0; h < HART_NUM; h++) begin
                hart_state[h] <= HART_IDLE;
            end
        end else begin
            if (hstart && hart_state[hs_id] == HART_IDLE) begin
                hart_state[hs_id] <= HART_ACTIVE;     // Visible next cycle
            end
            if (advance && sel_valid) begin
                last_hart <= sel_hart;                // Step the pointer
            end
        end
    end

endmodule

//--- hw/if_reg.sv
/*
 * Per-hart program counters and the registered fetch output.
 * Memory must return insn for fetch_pc within the same cycle.
 * A redirect kills a pending entry of its hart and its insn becomes a NOP.
 */
`timescale 1ns/1ps

module if_reg
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              sel_valid,              // A hart is selected
    input  logic [HART_W-1:0] sel_hart,               // Selected hart
    input  hart_state_t       hart_state [HART_NUM],  // For the idle test
    input  logic              hstart,                 // Start request pulse
    input  logic [HART_W-1:0] hs_id,
    input  logic [WORD_W-1:0] hs_pc,
    input  logic              redirect,               // Jump from decode
    input  logic [HART_W-1:0] redirect_hart,
    input  logic [WORD_W-1:0] redirect_pc,
    output logic [WORD_W-1:0] fetch_pc,               // To instruction memory
    input  logic [WORD_W-1:0] insn,                   // Same-cycle memory data
    output logic              advance,                // Not holding
    fetch_bus.source          out
);

    logic [WORD_W-1:0] pc_r [HART_NUM];               // One counter per hart
    fetch_entry_t      entry_q;                       // Output entry
    logic              valid_q;
    logic              hold;                          // Entry waiting for accept
    logic              take;                          // Capture a fetch now
    logic              start_ok;                      // Start hits an idle hart
    logic              kill_new;                      // Redirect hits new fetch
    logic              kill_held;                     // Redirect hits held entry

    assign fetch_pc  = pc_r[sel_hart];
    assign hold      = valid_q && !out.accept;
    assign advance   = !hold;
    assign take      = sel_valid && !hold;
    assign start_ok  = hstart && (hart_state[hs_id] == HART_IDLE);
    assign kill_new  = redirect && (redirect_hart == sel_hart);
    assign kill_held = redirect && (redirect_hart == entry_q.hart);

    assign out.valid = valid_q;
    assign out.entry = entry_q;

    ////////////////////////////////////////////////////////////////////////////
    // Counters
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int h = 0; h < HART_NUM; h++) begin
                pc_r[h] <= '0;
            end
        end else begin
            for (int h = 0; h < HART_NUM; h++) begin
                if (start_ok && hs_id == HART_W'(h)) begin
                    pc_r[h] <= hs_pc;                  // Initial pc
                end else if (redirect && redirect_hart == HART_W'(h)) begin
                    pc_r[h] <= redirect_pc;            // Jump target wins over +4
                end else if (take && sel_hart == HART_W'(h)) begin
                    pc_r[h] <= pc_r[h] + WORD_W'(4);   // Sequential
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= !kill_new;                      // Wrong path if redirected
        end else if (!hold || kill_held) begin
            valid_q <= 1'b0;                           // Accepted, idle or killed
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            entry_q.pc   <= fetch_pc;
            entry_q.insn <= kill_new ? OP_NOP : insn;
            entry_q.hart <= sel_hart;
        end else if (hold && kill_held) begin
            entry_q.insn <= OP_NOP;                    // Dead entry
        end
    end

endmodule

//--- hw/fetch_queue.sv
/*
 * Synchronous FIFO of fetch entries on valid/accept channels.
 * Accepts only while not full, even when a pop happens in the same cycle.
 * A pushed entry reaches the head one cycle after the push.
 */
`timescale 1ns/1ps

module fetch_queue #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 4
)(
    input  logic     clk,
    input  logic     rst,
    fetch_bus.sink   in,
    fetch_bus.source out
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t           mem [DEPTH];                    // Entry storage
    logic [PTR_W-1:0] wr_ptr;                         // Next slot to write
    logic [PTR_W-1:0] rd_ptr;                         // Head slot
    logic [CNT_W-1:0] count;                          // Occupancy
    logic             push;
    logic             pop;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in.accept = (count != CNT_W'(DEPTH));      // Not full
    assign out.valid = (count != '0);                 // Not empty
    assign out.entry = mem[rd_ptr];
    assign push      = in.valid && in.accept;
    assign pop       = out.valid && out.accept;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in.entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);   // Both may happen
        end
    end

endmodule

//--- hw/decode_stage.sv
/*
 * Pops fetches, drops wrong-path ones and registers the survivors.
 * A hart's first entry after reset sets its expected pc.
 * Wrong-path entries are popped even while dec_hold is high.
 */
`timescale 1ns/1ps

module decode_stage
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    fetch_bus.sink            in,
    input  logic              dec_hold,               // Output back-pressure
    output logic              dec_valid,
    output logic [WORD_W-1:0] dec_pc,
    output logic [WORD_W-1:0] dec_insn,
    output logic [HART_W-1:0] dec_hart,
    output logic              dec_is_jump,
    output logic              redirect,               // One-cycle pulse
    output logic [HART_W-1:0] redirect_hart,
    output logic [WORD_W-1:0] redirect_pc
);

    logic [WORD_W-1:0]   exp_pc [HART_NUM];           // Next correct pc per hart
    logic [HART_NUM-1:0] exp_set;                     // exp_pc holds a real value
    fetch_entry_t        head;
    logic                is_jump;
    logic                drop;                        // Wrong path, discard
    logic                keep;                        // Load into output
    logic [WORD_W-1:0]   j_imm;
    logic [WORD_W-1:0]   next_pc;

    assign head    = in.entry;
    assign is_jump = (head.insn[6:0] == OPC_JAL);
    // J-type immediate, sign extended
    assign j_imm   = {{12{head.insn[31]}}, head.insn[19:12], head.insn[20],
                      head.insn[30:21], 1'b0};
    assign next_pc = is_jump ? head.pc + j_imm : head.pc + WORD_W'(4);
    assign drop    = in.valid && exp_set[head.hart] && (head.pc != exp_pc[head.hart]);
    assign keep    = in.valid && !drop && !dec_hold;
    assign in.accept = drop || !dec_hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            exp_set <= '0;
        end else if (keep) begin
            exp_set[head.hart] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            exp_pc[head.hart] <= next_pc;              // Follows taken JAL
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register and redirect
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
            redirect  <= 1'b0;
        end else begin
            if (!dec_hold) begin
                dec_valid <= keep;                     // Frozen under hold
            end
            redirect <= keep && is_jump;
        end
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            dec_pc        <= head.pc;
            dec_insn      <= head.insn;
            dec_hart      <= head.hart;
            dec_is_jump   <= is_jump;
            redirect_hart <= head.hart;
            redirect_pc   <= next_pc;
        end
    end

endmodule

//--- hw/fetch_top.sv
/*
 * Fetch front end of a four-hart barrel core.
 * Instruction memory sits outside and answers fetch_pc in the same cycle.
 * Output latency depends on queue occupancy and dec_hold.
 */
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4                     // Fetch queue entries
)(
    input  logic              clk,
    input  logic              rst,
    input  logic              hstart,
    input  logic [HART_W-1:0] hs_id,
    input  logic [WORD_W-1:0] hs_pc,
    output logic [WORD_W-1:0] fetch_pc,
    input  logic [WORD_W-1:0] insn,
    input  logic              dec_hold,
    output logic              dec_valid,
    output logic [WORD_W-1:0] dec_pc,
    output logic [WORD_W-1:0] dec_insn,
    output logic [HART_W-1:0] dec_hart,
    output logic              dec_is_jump
);

    logic              sel_valid;
    logic [HART_W-1:0] sel_hart;
    hart_state_t       hart_state [HART_NUM];
    logic              advance;
    logic              redirect;
    logic [HART_W-1:0] redirect_hart;
    logic [WORD_W-1:0] redirect_pc;

    fetch_bus #(.entry_t(fetch_entry_t)) fq_in_bus ();    // if_reg to queue
    fetch_bus #(.entry_t(fetch_entry_t)) fq_out_bus ();   // Queue to decode

    hart_ctrl u_hart_ctrl (
        .clk(clk), .rst(rst), .hstart(hstart), .hs_id(hs_id), .advance(advance),
        .sel_valid(sel_valid), .sel_hart(sel_hart), .hart_state(hart_state)
    );

    if_reg u_if_reg (
        .clk(clk), .rst(rst), .sel_valid(sel_valid), .sel_hart(sel_hart),
        .hart_state(hart_state), .hstart(hstart), .hs_id(hs_id), .hs_pc(hs_pc),
        .redirect(redirect), .redirect_hart(redirect_hart), .redirect_pc(redirect_pc),
        .fetch_pc(fetch_pc), .insn(insn), .advance(advance), .out(fq_in_bus.source)
    );

    fetch_queue #(.entry_t(fetch_entry_t), .DEPTH(QUEUE_DEPTH)) u_fetch_queue (
        .clk(clk), .rst(rst), .in(fq_in_bus.sink), .out(fq_out_bus.source)
    );

    decode_stage u_decode_stage (
        .clk(clk), .rst(rst), .in(fq_out_bus.sink), .dec_hold(dec_hold),
        .dec_valid(dec_valid), .dec_pc(dec_pc), .dec_insn(dec_insn),
        .dec_hart(dec_hart), .dec_is_jump(dec_is_jump), .redirect(redirect),
        .redirect_hart(redirect_hart), .redirect_pc(redirect_pc)
    );

endmodule

//--- test/tb_clk.sv
/*
 * Testbench clock and reset source.
 * Reset is high for the first three rising edges and drops 1 ns after the third.
 */
`timescale 1ns/1ps

module tb_clk #(
    parameter int PERIOD_NS = 100                     // Full clock period
)(
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;                                // Synchronous release
    end

endmodule

//--- test/tb_mem.svh
/*
 * Instruction memory content as a pure function of the byte address.
 * Word 7 of every 8-word block is a JAL of 1 to 4 words forward or back.
 * The including module must import fetch_pkg.
 */

localparam logic [31:0] MEM_SEED = 32'h17b3_dda2;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// JAL slot of an 8-word block
function automatic logic jal_slot(input logic [31:0] addr);
    return addr[4:2] == 3'd7;
endfunction

// Byte offset of the JAL stored at addr, never zero
function automatic logic [31:0] jump_offset(input logic [31:0] addr);
    logic [31:0] r;
    logic [31:0] mag;
    r   = xorshift32(MEM_SEED ^ ~addr);
    mag = 32'({r[1:0], 2'b00}) + 32'd4;               // 4 to 16 bytes
    return r[2] ? -mag : mag;                         // Backward on bit 2
endfunction

function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] r;
    logic [31:0] off;
    r   = xorshift32(xorshift32(MEM_SEED ^ addr));    // Whole address mixed in
    off = jump_offset(addr);
    if (jal_slot(addr)) begin
        return {off[20], off[10:1], off[11], off[19:12], r[11:7], OPC_JAL};
    end
    // Filler words must not look like a JAL
    return (r[6:0] == OPC_JAL) ? {r[31:7], 7'b110_1110} : r;
endfunction

//--- test/tb_check.sv
/*
 * Output checker of the fetch front end.
 * Samples on the falling edge, where DUT outputs and driven inputs are settled.
 * An output counts as accepted when dec_valid is high and dec_hold is low.
 */
`timescale 1ns/1ps

module tb_check
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              hstart,
    input  logic [HART_W-1:0] hs_id,
    input  logic [WORD_W-1:0] hs_pc,
    input  logic              dec_hold,
    input  logic              dec_valid,
    input  logic [WORD_W-1:0] dec_pc,
    input  logic [WORD_W-1:0] dec_insn,
    input  logic [HART_W-1:0] dec_hart,
    input  logic              dec_is_jump,
    input  logic              run_done,               // Stimulus finished
    output int                error_count,
    output int                check_count
);

    `include "tb_mem.svh"

    logic [WORD_W-1:0]   exp_pc [HART_NUM];           // Next pc each hart must show
    logic [HART_NUM-1:0] started;                     // Hart active in the model
    int                  out_count [HART_NUM];        // Accepted outputs per hart
    int                  errors = 0;
    int                  checks = 0;
    logic                final_done = 1'b0;

    assign error_count = errors;
    assign check_count = checks;

    task automatic check_output();
        logic [WORD_W-1:0] want_insn;
        logic              want_jump;
        checks++;
        if (!started[dec_hart]) begin
            $display("%0t: output seen for hart %0d, which was never started", $time, dec_hart);
            errors++;
            return;
        end
        want_insn = mem_word(dec_pc);
        want_jump = jal_slot(dec_pc);                 // Only JAL slots hold a JAL
        if (dec_pc !== exp_pc[dec_hart]) begin
            $display("[ERROR] dec_pc hart %0d: got %h, expected %h",
                     dec_hart, dec_pc, exp_pc[dec_hart]);
            errors++;
        end
        if (dec_insn !== want_insn) begin
            $display("[ERROR] dec_insn at pc %h: got %h, expected %h",
                     dec_pc, dec_insn, want_insn);
            errors++;
        end
        if (dec_is_jump !== want_jump) begin
            $display("[ERROR] dec_is_jump at pc %h: got %h, expected %h",
                     dec_pc, dec_is_jump, want_jump);
            errors++;
        end
        // Resync on the observed pc so one slip is reported once
        exp_pc[dec_hart] = jal_slot(dec_pc) ? dec_pc + jump_offset(dec_pc) : dec_pc + 32'd4;
        out_count[dec_hart]++;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            started = '0;
            for (int h = 0; h < HART_NUM; h++) begin
                out_count[h] = 0;
            end
        end else begin
            if (dec_valid && !dec_hold) begin
                check_output();                       // Accepted this cycle
            end
            if (hstart && !started[hs_id]) begin
                started[hs_id] = 1'b1;                // Restart of active hart ignored
                exp_pc[hs_id]  = hs_pc;
            end
            if (run_done && !final_done) begin
                final_done = 1'b1;
                for (int h = 0; h < HART_NUM; h++) begin
                    if (out_count[h] == 0) begin
                        $display("Hart %0d produced no output during the run", h);
                        errors++;
                    end
                end
            end
        end
    end

endmodule

//--- test/tb_fetch_assert.sv
/*
 * Concurrent checks bound into the fetch queue and the decode stage.
 * Each bind ties the inputs it has no use for to zero.
 */
`timescale 1ns/1ps

module tb_fetch_assert
    import fetch_pkg::*;
#(
    parameter int DEPTH = 4,                          // Queue entries
    parameter int CNT_W = 3                           // Queue count width
)(
    input logic              clk,
    input logic              rst,
    input logic [CNT_W-1:0]  q_count,
    input logic              dec_hold,
    input logic              dec_valid,
    input logic [WORD_W-1:0] dec_pc,
    input logic [WORD_W-1:0] dec_insn,
    input logic [HART_W-1:0] dec_hart,
    input logic              dec_is_jump,
    input logic              redirect,
    input logic [HART_W-1:0] redirect_hart
);

    int fail_count = 0;                               // Failed assertions so far

    a_count_max: assert property (@(posedge clk) disable iff (rst)
        q_count <= CNT_W'(DEPTH))
        else begin
            $error("Queue count %0d above depth %0d", q_count, DEPTH);
            fail_count++;
        end

    // Output frozen under back-pressure
    a_valid_hold: assert property (@(posedge clk) disable iff (rst)
        dec_hold |=> $stable(dec_valid))
        else begin
            $error("dec_valid changed while dec_hold was high");
            fail_count++;
        end

    a_data_hold: assert property (@(posedge clk) disable iff (rst)
        (dec_hold && dec_valid) |=> $stable({dec_pc, dec_insn, dec_hart, dec_is_jump}))
        else begin
            $error("Decode output data changed while dec_hold was high");
            fail_count++;
        end

    // Redirect shows up beside the JAL output it came from
    a_redirect_src: assert property (@(posedge clk) disable iff (rst)
        redirect |-> (dec_valid && dec_is_jump && dec_insn[6:0] == OPC_JAL
                      && redirect_hart == dec_hart))
        else begin
            $error("Redirect pulse without a kept JAL");
            fail_count++;
        end

endmodule

bind fetch_queue tb_fetch_assert #(.DEPTH(DEPTH), .CNT_W(CNT_W)) u_queue_assert (
    .clk(clk), .rst(rst), .q_count(count), .dec_hold(1'b0), .dec_valid(1'b0),
    .dec_pc('0), .dec_insn('0), .dec_hart('0), .dec_is_jump(1'b0),
    .redirect(1'b0), .redirect_hart('0)
);

bind decode_stage tb_fetch_assert u_decode_assert (
    .clk(clk), .rst(rst), .q_count('0), .dec_hold(dec_hold), .dec_valid(dec_valid),
    .dec_pc(dec_pc), .dec_insn(dec_insn), .dec_hart(dec_hart), .dec_is_jump(dec_is_jump),
    .redirect(redirect), .redirect_hart(redirect_hart)
);

//--- test/tb_fetch.sv
/*
 * Testbench top of the fetch front end.
 * Memory answers fetch_pc combinationally; other inputs move 5 ns after the edge.
 * Each table row starts a hart on its first cycle and applies an 8-cycle hold duty.
 */
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*;
();

    `include "tb_mem.svh"

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 5;                    // Input delay after the edge
    localparam int NUM_ROWS   = 11;
    localparam int DRAIN      = 40;                   // Cycles with hold low at the end
    localparam int MARGIN     = 200;                  // Watchdog slack in cycles

    typedef struct packed {
        int                wait_cyc;                  // Row length in cycles
        logic              start;
        logic [HART_W-1:0] hart;
        logic [WORD_W-1:0] pc;
        logic [7:0]        hold;                      // dec_hold per cycle, bit 0 first
    } stim_row_t;

    stim_row_t stim [NUM_ROWS] = '{
        //  wait start  hart  pc             hold
        '{6,  1'b0, 2'd0, 32'h0000_0000, 8'h00},   // Nothing started yet
        '{40, 1'b1, 2'd0, 32'h0000_0100, 8'h00},   // Hart 0 alone
        '{30, 1'b1, 2'd0, 32'h0000_0800, 8'h0c},   // Restart of active hart 0
        '{40, 1'b1, 2'd2, 32'h0000_2040, 8'h00},
        '{40, 1'b1, 2'd1, 32'h0000_1000, 8'h55},   // Alternating hold
        '{40, 1'b1, 2'd3, 32'h0000_3ff0, 8'h00},   // All four running
        '{60, 1'b0, 2'd0, 32'h0000_0000, 8'hff},   // Long hold fills the queue
        '{60, 1'b0, 2'd0, 32'h0000_0000, 8'h00},
        '{40, 1'b1, 2'd1, 32'h0000_0000, 8'h91},   // Restart of active hart 1
        '{80, 1'b0, 2'd0, 32'h0000_0000, 8'hf0},   // Hold bursts
        '{60, 1'b0, 2'd0, 32'h0000_0000, 8'h00}
    };

    logic              clk;
    logic              rst;
    logic              hstart;
    logic [HART_W-1:0] hs_id;
    logic [WORD_W-1:0] hs_pc;
    logic [WORD_W-1:0] fetch_pc;
    logic [WORD_W-1:0] insn;
    logic              dec_hold;
    logic              dec_valid;
    logic [WORD_W-1:0] dec_pc;
    logic [WORD_W-1:0] dec_insn;
    logic [HART_W-1:0] dec_hart;
    logic              dec_is_jump;
    logic              run_done;
    int                error_count;
    int                check_count;

    assign insn = mem_word(fetch_pc);                 // Same-cycle memory

    tb_clk #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clk(clk), .rst(rst));

    fetch_top #(.QUEUE_DEPTH(4)) uut (
        .clk(clk), .rst(rst), .hstart(hstart), .hs_id(hs_id), .hs_pc(hs_pc),
        .fetch_pc(fetch_pc), .insn(insn), .dec_hold(dec_hold), .dec_valid(dec_valid),
        .dec_pc(dec_pc), .dec_insn(dec_insn), .dec_hart(dec_hart), .dec_is_jump(dec_is_jump)
    );

    tb_check u_check (
        .clk(clk), .rst(rst), .hstart(hstart), .hs_id(hs_id), .hs_pc(hs_pc),
        .dec_hold(dec_hold), .dec_valid(dec_valid), .dec_pc(dec_pc), .dec_insn(dec_insn),
        .dec_hart(dec_hart), .dec_is_jump(dec_is_jump), .run_done(run_done),
        .error_count(error_count), .check_count(check_count)
    );

    initial begin
        logic [2:0] phase;
        int         assert_errors;
        hstart   = 1'b0;
        hs_id    = '0;
        hs_pc    = '0;
        dec_hold = 1'b0;
        run_done = 1'b0;
        @(negedge rst);
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < stim[r].wait_cyc; c++) begin
                @(posedge clk);
                #DRIVE_DLY;
                phase    = 3'(c);
                hstart   = stim[r].start && (c == 0);  // One-cycle pulse
                hs_id    = stim[r].hart;
                hs_pc    = stim[r].pc;
                dec_hold = stim[r].hold[phase];
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
        hstart   = 1'b0;
        dec_hold = 1'b0;
        repeat (DRAIN) @(posedge clk);
        run_done = 1'b1;                              // Per-hart coverage check
        repeat (2) @(posedge clk);
        assert_errors = uut.u_fetch_queue.u_queue_assert.fail_count
                      + uut.u_decode_stage.u_decode_assert.fail_count;
        $display("Closing: %0d outputs checked, %0d errors, %0d assertion failures",
                 check_count, error_count, assert_errors);
        if (error_count == 0 && assert_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int limit;
        limit = 3 + 1 + DRAIN + 2 + MARGIN;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += stim[r].wait_cyc;
        end
        #(limit * CLK_PERIOD);
        $display("Watchdog: run still going after %0d cycles", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- src.f
+incdir+test
hw/fetch_pkg.sv
hw/fetch_bus.sv
hw/hart_ctrl.sv
hw/if_reg.sv
hw/fetch_queue.sv
hw/decode_stage.sv
hw/fetch_top.sv
test/tb_clk.sv
test/tb_check.sv
test/tb_fetch_assert.sv
test/tb_fetch.sv
